// File: source/mips_isa_pkg.sv
`default_nettype none

package mips_isa_pkg;

    // primary opcodes of the supported subset.
    typedef enum logic [5:0] {
        SPECIAL = 6'h00,
        ADDIU   = 6'h09,
        SLTIU   = 6'h0B,
        ANDI    = 6'h0C,
        ORI     = 6'h0D,
        LUI     = 6'h0F,
        LW      = 6'h23,
        SW      = 6'h2B
    } opcode_e;

    // function field, only meaningful when opcode is SPECIAL.
    typedef enum logic [5:0] {
        SLL  = 6'h00,
        SRL  = 6'h02,
        JR   = 6'h08,
        ADDU = 6'h21,
        SUBU = 6'h23,
        AND  = 6'h24,
        OR   = 6'h25,
        SLTU = 6'h2B
    } funct_e;

    typedef enum logic [3:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_SLTU,
        ALU_SLL,
        ALU_SRL,
        ALU_PASS_B  // lui, operand comes in pre-shifted.
    } alu_op_e;

    localparam logic [4:0] REG_V0 = 5'd2;  // result register $v0.

    typedef struct packed {
        opcode_e    opcode;
        logic [4:0] rs;
        logic [4:0] rt;
        logic [4:0] rd;
        logic [4:0] shamt;
        funct_e     funct;
    } r_fmt_t;

    typedef struct packed {
        opcode_e     opcode;
        logic [4:0]  rs;
        logic [4:0]  rt;
        logic [15:0] imm;
    } i_fmt_t;

    // one instruction word, two ways to read it.
    typedef union packed {
        r_fmt_t r_fmt;
        i_fmt_t i_fmt;
    } instr_t;

endpackage

`default_nettype wire

// File: source/avalon_pkg.sv
`default_nettype none

package avalon_pkg;

    // master to slave, held stable while waitrequest is high.
    typedef struct packed {
        logic [31:0] address;     // byte address, word aligned.
        logic        read;
        logic        write;
        logic [31:0] writedata;
        logic [3:0]  byteenable;
    } bus_req_t;

    // slave to master.
    typedef struct packed {
        logic [31:0] readdata;    // valid in the cycle waitrequest is low.
        logic        waitrequest;
    } bus_rsp_t;

endpackage

`default_nettype wire

// File: source/register_file.sv
`timescale 1ns/1ps
`default_nettype none

module register_file (
    input  logic        clk,
    input  logic        rst_n,
    input  logic [4:0]  rs_addr,
    input  logic [4:0]  rt_addr,
    input  logic        wr_en,
    input  logic [4:0]  wr_addr,
    input  logic [31:0] wr_data,
    output logic [31:0] rs_data,
    output logic [31:0] rt_data,
    output logic [31:0] v0
);

    logic [31:0] regs [0:31];

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < 32; i++) begin
                regs[i] <= 32'd0;
            end
        end else if (wr_en && wr_addr != 5'd0) begin
            regs[wr_addr] <= wr_data;  // $zero stays zero.
        end
    end

    // combinational read ports.
    always_comb begin
        rs_data = (rs_addr == 5'd0) ? 32'd0 : regs[rs_addr];
        rt_data = (rt_addr == 5'd0) ? 32'd0 : regs[rt_addr];
    end

    assign v0 = regs[mips_isa_pkg::REG_V0];

endmodule

`default_nettype wire

// File: source/alu.sv
`timescale 1ns/1ps
`default_nettype none

module alu (
    input  mips_isa_pkg::alu_op_e op,
    input  logic [31:0]           a,
    input  logic [31:0]           b,
    input  logic [4:0]            shamt,
    output logic [31:0]           y
);

    always_comb begin
        case (op)
            mips_isa_pkg::ALU_ADD: begin
                y = a + b;  // also forms lw/sw addresses.
            end
            mips_isa_pkg::ALU_SUB: begin
                y = a - b;
            end
            mips_isa_pkg::ALU_AND: begin
                y = a & b;
            end
            mips_isa_pkg::ALU_OR: begin
                y = a | b;
            end
            mips_isa_pkg::ALU_SLTU: begin
                // unsigned compare, even for a sign-extended immediate.
                y = (a < b) ? 32'd1 : 32'd0;
            end
            mips_isa_pkg::ALU_SLL: begin
                y = b << shamt;  // shifts act on rt.
            end
            mips_isa_pkg::ALU_SRL: begin
                y = b >> shamt;
            end
            mips_isa_pkg::ALU_PASS_B: begin
                y = b;
            end
            default: begin
                y = 32'd0;
            end
        endcase
    end

endmodule

`default_nettype wire

// File: source/cpu_control.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_control (
    input  logic                 clk,
    input  logic                 rst_n,
    input  mips_isa_pkg::instr_t instr,
    input  logic                 jr_target_zero,
    input  logic                 waitrequest,
    output logic                 fetch_read,
    output logic                 mem_read,
    output logic                 mem_write,
    output logic                 ir_load,
    output logic                 pc_load,
    output logic                 reg_write,
    output logic                 active
);

    typedef enum logic [1:0] {FETCH, EXECUTE, MEMORY, HALTED} state_e;

    state_e state;
    state_e state_next;
    logic   started;     // low only until the first clock after reset.
    logic   is_load;
    logic   is_mem;
    logic   is_jr;
    logic   writes_reg;

    always_comb begin
        is_load = instr.i_fmt.opcode == mips_isa_pkg::LW;
        is_mem = is_load || instr.i_fmt.opcode == mips_isa_pkg::SW;
        is_jr = instr.r_fmt.opcode == mips_isa_pkg::SPECIAL &&
                instr.r_fmt.funct == mips_isa_pkg::JR;
        case (instr.r_fmt.opcode)
            mips_isa_pkg::SPECIAL: writes_reg = !is_jr;
            mips_isa_pkg::ADDIU,
            mips_isa_pkg::SLTIU,
            mips_isa_pkg::ANDI,
            mips_isa_pkg::ORI,
            mips_isa_pkg::LUI:     writes_reg = 1'b1;
            default:               writes_reg = 1'b0;  // lw writes in memory.
        endcase
    end

    always_comb begin
        state_next = state;
        case (state)
            FETCH:   if (!waitrequest) state_next = EXECUTE;
            EXECUTE: begin
                if (is_jr && jr_target_zero) state_next = HALTED;
                else if (is_mem)             state_next = MEMORY;
                else                         state_next = FETCH;
            end
            MEMORY:  if (!waitrequest) state_next = FETCH;
            HALTED:  if (!started) state_next = FETCH;  // leave reset, else stay.
        endcase
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state   <= HALTED;
            started <= 1'b0;
        end else begin
            state   <= state_next;
            started <= 1'b1;
        end
    end

    assign fetch_read = state == FETCH;
    assign mem_read   = state == MEMORY && is_load;
    assign mem_write  = state == MEMORY && is_mem && !is_load;
    assign ir_load    = fetch_read && !waitrequest;
    assign pc_load    = state == EXECUTE;  // pc moves on for every instruction.
    assign reg_write  = (state == EXECUTE && writes_reg) || (mem_read && !waitrequest);
    assign active     = state != HALTED;

endmodule

`default_nettype wire

// File: source/mips_cpu.sv
`timescale 1ns/1ps
`default_nettype none

module mips_cpu #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0004
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  avalon_pkg::bus_rsp_t bus_rsp,
    output avalon_pkg::bus_req_t bus_req,
    output logic                 active,
    output logic [31:0]          register_v0
);

    mips_isa_pkg::instr_t  ir;
    mips_isa_pkg::alu_op_e alu_op;
    logic [31:0] pc;
    logic [31:0] rs_data;
    logic [31:0] rt_data;
    logic [31:0] imm_ext;
    logic [31:0] alu_b;
    logic [31:0] alu_y;
    logic [31:0] wr_data;
    logic [4:0]  wr_addr;
    logic        is_rtype;
    logic        is_jr;
    logic        fetch_read;
    logic        mem_read;
    logic        mem_write;
    logic        ir_load;
    logic        pc_load;
    logic        reg_write;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            pc <= RESET_VECTOR;
            ir <= '0;  // decodes as a nop.
        end else begin
            if (ir_load) ir <= bus_rsp.readdata;
            if (pc_load) pc <= is_jr ? rs_data : pc + 32'd4;  // no delay slot.
        end
    end

    always_comb begin
        is_rtype = ir.r_fmt.opcode == mips_isa_pkg::SPECIAL;
        is_jr = is_rtype && ir.r_fmt.funct == mips_isa_pkg::JR;
        case (ir.i_fmt.opcode)
            mips_isa_pkg::ANDI,
            mips_isa_pkg::ORI: imm_ext = {16'h0000, ir.i_fmt.imm};   // logical ops zero-extend.
            mips_isa_pkg::LUI: imm_ext = {ir.i_fmt.imm, 16'h0000};
            default:           imm_ext = {{16{ir.i_fmt.imm[15]}}, ir.i_fmt.imm};
        endcase
        alu_b   = is_rtype ? rt_data : imm_ext;
        wr_addr = is_rtype ? ir.r_fmt.rd : ir.i_fmt.rt;
        wr_data = mem_read ? bus_rsp.readdata : alu_y;
    end

    always_comb begin
        case (ir.i_fmt.opcode)
            mips_isa_pkg::SPECIAL: begin
                case (ir.r_fmt.funct)
                    mips_isa_pkg::SUBU: alu_op = mips_isa_pkg::ALU_SUB;
                    mips_isa_pkg::AND:  alu_op = mips_isa_pkg::ALU_AND;
                    mips_isa_pkg::OR:   alu_op = mips_isa_pkg::ALU_OR;
                    mips_isa_pkg::SLTU: alu_op = mips_isa_pkg::ALU_SLTU;
                    mips_isa_pkg::SLL:  alu_op = mips_isa_pkg::ALU_SLL;
                    mips_isa_pkg::SRL:  alu_op = mips_isa_pkg::ALU_SRL;
                    default:            alu_op = mips_isa_pkg::ALU_ADD;
                endcase
            end
            mips_isa_pkg::SLTIU: alu_op = mips_isa_pkg::ALU_SLTU;
            mips_isa_pkg::ANDI:  alu_op = mips_isa_pkg::ALU_AND;
            mips_isa_pkg::ORI:   alu_op = mips_isa_pkg::ALU_OR;
            mips_isa_pkg::LUI:   alu_op = mips_isa_pkg::ALU_PASS_B;
            default:             alu_op = mips_isa_pkg::ALU_ADD;  // addiu, lw, sw.
        endcase
    end

    // fetch reads at pc, the memory phase at rs + imm.
    always_comb begin
        bus_req.address    = fetch_read ? pc : alu_y;
        bus_req.read       = fetch_read || mem_read;
        bus_req.write      = mem_write;
        bus_req.writedata  = rt_data;
        bus_req.byteenable = 4'hF;
    end

    register_file u_regs (
        .clk     (clk),
        .rst_n   (rst_n),
        .rs_addr (ir.r_fmt.rs),
        .rt_addr (ir.r_fmt.rt),
        .wr_en   (reg_write),
        .wr_addr (wr_addr),
        .wr_data (wr_data),
        .rs_data (rs_data),
        .rt_data (rt_data),
        .v0      (register_v0)
    );

    alu u_alu (.op(alu_op), .a(rs_data), .b(alu_b), .shamt(ir.r_fmt.shamt), .y(alu_y));

    cpu_control u_ctrl (
        .clk            (clk),
        .rst_n          (rst_n),
        .instr          (ir),
        .jr_target_zero (rs_data == 32'd0),
        .waitrequest    (bus_rsp.waitrequest),
        .fetch_read     (fetch_read),
        .mem_read       (mem_read),
        .mem_write      (mem_write),
        .ir_load        (ir_load),
        .pc_load        (pc_load),
        .reg_write      (reg_write),
        .active         (active)
    );

endmodule

`default_nettype wire

// File: source/avalon_ram.sv
`timescale 1ns/1ps
`default_nettype none

module avalon_ram #(
    parameter int RAM_WORDS   = 64,
    parameter int WAIT_CYCLES = 2
) (
    input  logic                 clk,
    input  logic                 rst_n,
    input  avalon_pkg::bus_req_t bus_req,
    output avalon_pkg::bus_rsp_t bus_rsp,
    input  logic                 inst_input,
    input  logic [7:0]           inst_addr,
    input  logic [31:0]          instruction
);

    localparam int AW = $clog2(RAM_WORDS);
    localparam int CW = $clog2(WAIT_CYCLES + 2);

    logic [31:0]   mem [0:RAM_WORDS-1];
    logic [AW-1:0] bus_idx;
    logic [AW-1:0] load_idx;
    logic [CW-1:0] wait_cnt;
    logic          strobe;
    logic          stall;

    assign bus_idx  = bus_req.address[AW+1:2];  // upper bits wrap.
    assign load_idx = AW'(inst_addr >> 2);
    assign strobe   = bus_req.read || bus_req.write;
    assign stall    = strobe && (wait_cnt < CW'(WAIT_CYCLES));

    // counts wait cycles, back to zero once the transfer completes.
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            wait_cnt <= '0;
        end else if (stall) begin
            wait_cnt <= wait_cnt + 1'b1;
        end else begin
            wait_cnt <= '0;
        end
    end

    always_ff @(posedge clk) begin
        if (inst_input) begin
            mem[load_idx] <= instruction;  // load port wins.
        end else if (bus_req.write && !stall) begin
            for (int b = 0; b < 4; b++) begin
                if (bus_req.byteenable[b]) begin
                    mem[bus_idx][8*b +: 8] <= bus_req.writedata[8*b +: 8];
                end
            end
        end
    end

    always_comb begin
        bus_rsp.readdata    = mem[bus_idx];
        bus_rsp.waitrequest = stall;
    end

endmodule

`default_nettype wire

// File: source/system_top.sv
`timescale 1ns/1ps
`default_nettype none

module system_top #(
    parameter logic [31:0] RESET_VECTOR = 32'h0000_0004,
    parameter int          RAM_WORDS    = 64,
    parameter int          WAIT_CYCLES  = 2
) (
    input  logic        clk,
    input  logic        rst_n,
    input  logic        inst_input,
    input  logic [7:0]  inst_addr,
    input  logic [31:0] instruction,
    output logic        active,
    output logic [31:0] register_v0
);

    avalon_pkg::bus_req_t bus_req;
    avalon_pkg::bus_rsp_t bus_rsp;

    mips_cpu #(.RESET_VECTOR(RESET_VECTOR)) u_cpu (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_rsp     (bus_rsp),
        .bus_req     (bus_req),
        .active      (active),
        .register_v0 (register_v0)
    );

    avalon_ram #(.RAM_WORDS(RAM_WORDS), .WAIT_CYCLES(WAIT_CYCLES)) u_ram (
        .clk         (clk),
        .rst_n       (rst_n),
        .bus_req     (bus_req),
        .bus_rsp     (bus_rsp),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction)
    );

endmodule

`default_nettype wire

// File: tb/cpu_checker.sv
`timescale 1ns/1ps
`default_nettype none

module cpu_checker (
    input logic                 clk,
    input logic                 rst_n,
    input avalon_pkg::bus_req_t bus_req,
    input avalon_pkg::bus_rsp_t bus_rsp,
    input logic                 active
);

    logic strobe;

    assign strobe = bus_req.read || bus_req.write;

    read_write_exclusive: assert property (@(posedge clk) disable iff (!rst_n)
        !(bus_req.read && bus_req.write))
        else $error("read and write are high in the same cycle");

    word_aligned: assert property (@(posedge clk) disable iff (!rst_n)
        strobe |-> bus_req.address[1:0] == 2'b00)
        else $error("bus address is not word aligned");

    // the whole request is held while the slave stalls.
    held_while_waiting: assert property (@(posedge clk) disable iff (!rst_n)
        strobe && bus_rsp.waitrequest |=> $stable(bus_req))
        else $error("bus request changed while waitrequest was high");

    quiet_when_halted: assert property (@(posedge clk) disable iff (!rst_n)
        !active |-> !strobe)
        else $error("bus strobe seen while the processor is halted");

endmodule

bind mips_cpu cpu_checker u_checker (
    .clk     (clk),
    .rst_n   (rst_n),
    .bus_req (bus_req),
    .bus_rsp (bus_rsp),
    .active  (active)
);

`default_nettype wire

// File: tb/system_tb.sv
`timescale 1ns/1ps
`default_nettype none

module system_tb;

    localparam logic [31:0] RESET_VECTOR = 32'h0000_0004;
    localparam int          NUM_PROGRAMS = 13;
    localparam int          CYCLE_LIMIT  = 400 * NUM_PROGRAMS;  // about 8x the longest run.
    localparam logic [4:0]  ZERO = 5'd0;
    localparam logic [4:0]  T0   = 5'd8;
    localparam logic [4:0]  T1   = 5'd9;
    localparam logic [4:0]  V0   = mips_isa_pkg::REG_V0;

    localparam mips_isa_pkg::funct_e ALU_FUNCTS [5] = '{
        mips_isa_pkg::ADDU, mips_isa_pkg::SUBU, mips_isa_pkg::AND,
        mips_isa_pkg::OR, mips_isa_pkg::SLTU
    };

    logic        clk;
    logic        rst_n;
    logic        inst_input;
    logic [7:0]  inst_addr;
    logic [31:0] instruction;
    logic        active;
    logic [31:0] register_v0;

    logic [31:0] prog [$];   // words placed from RESET_VECTOR on.
    logic [31:0] expected_v0;
    logic        armed;
    int          cycles;
    int          tests;
    int          checks;
    int          errors;
    event        checked;

    system_top #(.RESET_VECTOR(RESET_VECTOR), .RAM_WORDS(64), .WAIT_CYCLES(2)) UUT (
        .clk         (clk),
        .rst_n       (rst_n),
        .inst_input  (inst_input),
        .inst_addr   (inst_addr),
        .instruction (instruction),
        .active      (active),
        .register_v0 (register_v0)
    );

    always #4 clk = ~clk;

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("timeout: the processor did not halt within %0d cycles", CYCLE_LIMIT);
            $display("Some tests failed");
            $finish;
        end
    end

    function automatic logic [31:0] rtype(input mips_isa_pkg::funct_e funct,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [4:0] rd, input logic [4:0] shamt);
        mips_isa_pkg::instr_t w;
        w.r_fmt.opcode = mips_isa_pkg::SPECIAL;
        w.r_fmt.rs     = rs;
        w.r_fmt.rt     = rt;
        w.r_fmt.rd     = rd;
        w.r_fmt.shamt  = shamt;
        w.r_fmt.funct  = funct;
        return w;
    endfunction

    function automatic logic [31:0] itype(input mips_isa_pkg::opcode_e op,
                                          input logic [4:0] rs, input logic [4:0] rt,
                                          input logic [15:0] imm);
        mips_isa_pkg::instr_t w;
        w.i_fmt.opcode = op;
        w.i_fmt.rs     = rs;
        w.i_fmt.rt     = rt;
        w.i_fmt.imm    = imm;
        return w;
    endfunction

    // lui then ori, so any 32-bit value fits.
    task automatic push_constant(input logic [4:0] rd, input logic [31:0] value);
        prog.push_back(itype(mips_isa_pkg::LUI, ZERO, rd, value[31:16]));
        prog.push_back(itype(mips_isa_pkg::ORI, rd, rd, value[15:0]));
    endtask

    // interpreter of the kept instructions, from a cleared register file.
    function automatic logic [31:0] run_program();
        logic [31:0] mem [0:63];
        logic [31:0] regs [0:31];
        logic [31:0] pc;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] sext;
        logic [31:0] addr;
        mips_isa_pkg::instr_t w;
        for (int i = 0; i < 64; i++) mem[i] = 32'd0;
        for (int i = 0; i < 32; i++) regs[i] = 32'd0;
        foreach (prog[i]) mem[(RESET_VECTOR >> 2) + i] = prog[i];
        pc = RESET_VECTOR;
        for (int step = 0; step < 1000; step++) begin
            w = mem[pc[7:2]];
            a = regs[w.r_fmt.rs];
            b = regs[w.r_fmt.rt];
            sext = {{16{w.i_fmt.imm[15]}}, w.i_fmt.imm};
            addr = a + sext;
            pc = pc + 32'd4;
            case (w.i_fmt.opcode)
                mips_isa_pkg::SPECIAL: begin
                    case (w.r_fmt.funct)
                        mips_isa_pkg::SLL:  regs[w.r_fmt.rd] = b << w.r_fmt.shamt;
                        mips_isa_pkg::SRL:  regs[w.r_fmt.rd] = b >> w.r_fmt.shamt;
                        mips_isa_pkg::ADDU: regs[w.r_fmt.rd] = a + b;
                        mips_isa_pkg::SUBU: regs[w.r_fmt.rd] = a - b;
                        mips_isa_pkg::AND:  regs[w.r_fmt.rd] = a & b;
                        mips_isa_pkg::OR:   regs[w.r_fmt.rd] = a | b;
                        mips_isa_pkg::SLTU: regs[w.r_fmt.rd] = {31'd0, a < b};
                        mips_isa_pkg::JR: begin
                            if (a == 32'd0) return regs[V0];
                            pc = a;
                        end
                        default: ;
                    endcase
                end
                mips_isa_pkg::ADDIU: regs[w.i_fmt.rt] = a + sext;
                mips_isa_pkg::SLTIU: regs[w.i_fmt.rt] = {31'd0, a < sext};  // unsigned.
                mips_isa_pkg::ANDI:  regs[w.i_fmt.rt] = a & {16'h0000, w.i_fmt.imm};
                mips_isa_pkg::ORI:   regs[w.i_fmt.rt] = a | {16'h0000, w.i_fmt.imm};
                mips_isa_pkg::LUI:   regs[w.i_fmt.rt] = {w.i_fmt.imm, 16'h0000};
                mips_isa_pkg::LW:    regs[w.i_fmt.rt] = mem[addr[7:2]];
                mips_isa_pkg::SW:    mem[addr[7:2]] = b;
                default: ;
            endcase
            regs[0] = 32'd0;
        end
        return 32'hDEAD_BEEF;  // program never reached jr $0.
    endfunction

    task automatic check_value(input logic [31:0] actual, input logic [31:0] expected,
                               input string what);
        checks++;
        if (actual !== expected) begin
            errors++;
            $display("Fail at %0t ns: %s is %h, expected %h", $time, what, actual, expected);
        end
    endtask

    // program goes in while rst_n is low, then two more reset cycles.
    task automatic load_program();
        @(posedge clk);
        rst_n <= 1'b0;
        foreach (prog[i]) begin
            @(posedge clk);
            inst_input  <= 1'b1;
            inst_addr   <= 8'(RESET_VECTOR + 32'(4 * i));
            instruction <= prog[i];
        end
        @(posedge clk);
        inst_input <= 1'b0;
        repeat (2) @(posedge clk);
        rst_n <= 1'b1;
    endtask

    task automatic test_program(input string name);
        int errors_before;
        errors_before = errors;
        load_program();
        expected_v0 = run_program();
        wait (active === 1'b1);
        armed = 1'b1;
        @(checked);
        armed = 1'b0;
        tests++;
        $display("test %0d %s: %s", tests, name, (errors == errors_before) ? "ok" : "mismatch");
        prog.delete();
    endtask

    always begin
        @(negedge active);
        if (armed) begin
            @(negedge clk);  // mid cycle, v0 is settled.
            check_value(register_v0, expected_v0, "register_v0 after halt");
            -> checked;
        end
    end

    initial begin
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] rnd;
        void'($urandom(7501));
        clk         = 1'b0;
        rst_n       = 1'b0;
        inst_input  = 1'b0;
        inst_addr   = 8'd0;
        instruction = 32'd0;
        armed       = 1'b0;
        expected_v0 = 32'd0;
        cycles      = 0;
        tests       = 0;
        checks      = 0;
        errors      = 0;

        // sign-extended immediate against an unsigned compare.
        prog.push_back(itype(mips_isa_pkg::ADDIU, ZERO, V0, 16'hFFF0));
        prog.push_back(rtype(mips_isa_pkg::SLL, ZERO, V0, V0, 5'd16));
        prog.push_back(itype(mips_isa_pkg::SLTIU, V0, V0, 16'hFFFF));
        prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
        test_program("reference");

        foreach (ALU_FUNCTS[i]) begin
            a = $urandom();
            b = $urandom();
            push_constant(T0, a);
            push_constant(T1, b);
            prog.push_back(rtype(ALU_FUNCTS[i], T0, T1, V0, 5'd0));
            prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
            test_program(ALU_FUNCTS[i].name());
        end

        for (int i = 0; i < 4; i++) begin
            a = $urandom();
            rnd = $urandom();
            push_constant(T0, a);
            case (i)
                0: prog.push_back(rtype(mips_isa_pkg::SLL, ZERO, T0, V0, rnd[4:0]));
                1: prog.push_back(rtype(mips_isa_pkg::SRL, ZERO, T0, V0, rnd[4:0]));
                2: prog.push_back(itype(mips_isa_pkg::ANDI, T0, V0, rnd[15:0]));
                default: prog.push_back(itype(mips_isa_pkg::ORI, T0, V0, rnd[15:0]));
            endcase
            prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
            test_program("shift and logic immediate");
        end

        // store through a base register, clear the source, load it back.
        push_constant(T0, $urandom());
        prog.push_back(itype(mips_isa_pkg::ADDIU, ZERO, T1, 16'h00B0));
        prog.push_back(itype(mips_isa_pkg::SW, T1, T0, 16'h0010));
        prog.push_back(itype(mips_isa_pkg::ORI, ZERO, T0, 16'h0000));
        prog.push_back(itype(mips_isa_pkg::LW, T1, V0, 16'h0010));
        prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
        test_program("store and load");

        // second program reads v0 and t1, which reset must have cleared.
        push_constant(V0, $urandom());
        push_constant(T1, $urandom());
        prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
        test_program("fill registers");
        prog.push_back(rtype(mips_isa_pkg::ADDU, V0, T1, V0, 5'd0));
        prog.push_back(itype(mips_isa_pkg::ADDIU, V0, V0, 16'h0005));
        prog.push_back(rtype(mips_isa_pkg::JR, ZERO, ZERO, ZERO, 5'd0));
        test_program("reload after reset");

        $display("%0d tests, %0d checks, %0d errors", tests, checks, errors);
        if (errors == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

`default_nettype wire

// File: all.f
source/mips_isa_pkg.sv
source/avalon_pkg.sv
source/register_file.sv
source/alu.sv
source/cpu_control.sv
source/mips_cpu.sv
source/avalon_ram.sv
source/system_top.sv
tb/cpu_checker.sv
tb/system_tb.sv

// File: run.sh
#!/bin/sh
# compile and run the testbench with Verilator, result decided from the log.

cd "$(dirname "$0")" || exit 1
LOG=sim.log

verilator --binary --timing --assert -Wno-fatal -f all.f --top-module system_tb -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/Vsystem_tb > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation ended with status $status"
    exit 1
fi

if grep -q "Some tests failed" "$LOG"; then
    exit 1
fi
exit 0
